// ==== include/core_settings.svh ====
// Global sizes and instruction field positions for the dual-issue core
// Include wherever a width or field slice is needed
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define XLEN        32
`define REG_COUNT   32
`define REG_IDX_W   5
`define INSTR_W     32
`define READ_PORTS  4

// Instruction fields
`define OPC_HI      31
`define OPC_LO      28
`define RD_HI       27
`define RD_LO       23
`define RS1_HI      22
`define RS1_LO      18
`define RS2_HI      17
`define RS2_LO      13
`define IMM_HI      12
`define IMM_LO      0

`endif

// ==== design/dualIssuePkg.sv ====
// Shared types of the dual-issue core
// Imported by every stage and by the testbench
`include "core_settings.svh"

package dualIssuePkg;

    // --------------------
    // Data and index types
    // --------------------

    // One architectural register value
    typedef logic [`XLEN-1:0] dataWord;

    // Register number, 0 is the hardwired zero register
    typedef logic [`REG_IDX_W-1:0] regIndex;

    // --------------------
    // ALU operations
    // --------------------

    // Encoded exactly as the opcode field of an instruction
    typedef enum logic [3:0] {
        // Empty slot, no retire
        NOP  = 4'h0,
        ADD  = 4'h1,
        SUB  = 4'h2,
        AND  = 4'h3,
        OR   = 4'h4,
        XOR  = 4'h5,
        // Shift amount from low bits of operand B
        SLL  = 4'h6,
        SRL  = 4'h7,
        // Signed less-than, result 0 or 1
        SLT  = 4'h8,
        // rs1 plus sign-extended immediate
        ADDI = 4'h9
    } aluOp;

endpackage

// ==== design/regFile.sv ====
// 4-read 2-write register file with same-cycle write forwarding
// Write port 0 carries the older instruction, port 1 the younger
`include "core_settings.svh"

module regFile import dualIssuePkg::*; (
    input  logic    clk,
    input  logic    rst,
    // Read ports
    input  regIndex rdIdx0_i,
    input  regIndex rdIdx1_i,
    input  regIndex rdIdx2_i,
    input  regIndex rdIdx3_i,
    output dataWord rdData0_o,
    output dataWord rdData1_o,
    output dataWord rdData2_o,
    output dataWord rdData3_o,
    // Write port 0, older slot
    input  logic    wrEn0_i,
    input  regIndex wrIdx0_i,
    input  dataWord wrData0_i,
    // Write port 1, younger slot
    input  logic    wrEn1_i,
    input  regIndex wrIdx1_i,
    input  dataWord wrData1_i
);

    // No storage behind register 0
    dataWord regs [1:`REG_COUNT-1];

    regIndex rdIdx  [`READ_PORTS];
    dataWord rdData [`READ_PORTS];

    assign rdIdx[0] = rdIdx0_i;
    assign rdIdx[1] = rdIdx1_i;
    assign rdIdx[2] = rdIdx2_i;
    assign rdIdx[3] = rdIdx3_i;

    assign rdData0_o = rdData[0];
    assign rdData1_o = rdData[1];
    assign rdData2_o = rdData[2];
    assign rdData3_o = rdData[3];

    // --------------------
    // Read with forwarding
    // --------------------
    // Zero register first, then port 0, then port 1, then storage
    for (genvar p = 0; p < `READ_PORTS; p++) begin : gRead
        assign rdData[p] = (rdIdx[p] == '0)                     ? '0        :
                           (wrEn0_i && (wrIdx0_i == rdIdx[p])) ? wrData0_i :
                           (wrEn1_i && (wrIdx1_i == rdIdx[p])) ? wrData1_i :
                                                                 regs[rdIdx[p]];
    end

    // --------------------
    // Write
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int r = 1; r < `REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (wrEn0_i && (wrIdx0_i != '0)) begin
                regs[wrIdx0_i] <= wrData0_i;
            end
            // Later statement, so younger data lands on a shared index
            if (wrEn1_i && (wrIdx1_i != '0)) begin
                regs[wrIdx1_i] <= wrData1_i;
            end
        end
    end

    // Result stage must have squashed the older of two same-index writes
    noWriteCollision: assert property (@(posedge clk) disable iff (!rst)
        (wrEn0_i && wrEn1_i) |-> (wrIdx0_i != wrIdx1_i));

endmodule

// ==== design/decodeStage.sv ====
// Decode of an instruction pair, operand read and dependency stall
// Holds the decoded pair for one cycle in front of execute
`include "core_settings.svh"

module decodeStage import dualIssuePkg::*; (
    input  logic                clk,
    input  logic                rst,
    // Issue side
    input  logic                issueValid_i,
    input  logic [`INSTR_W-1:0] instr0_i,
    input  logic [`INSTR_W-1:0] instr1_i,
    output logic                issueReady_o,
    // Register file reads
    output regIndex             rdIdx0_o,
    output regIndex             rdIdx1_o,
    output regIndex             rdIdx2_o,
    output regIndex             rdIdx3_o,
    input  dataWord             rdData0_i,
    input  dataWord             rdData1_i,
    input  dataWord             rdData2_i,
    input  dataWord             rdData3_i,
    // Decoded pair towards execute
    output logic                slotValid0_o,
    output logic                slotValid1_o,
    output aluOp                op0_o,
    output aluOp                op1_o,
    output regIndex             rd0_o,
    output regIndex             rd1_o,
    output dataWord             opA0_o,
    output dataWord             opA1_o,
    output dataWord             opB0_o,
    output dataWord             opB1_o,
    output regIndex             rs1Idx1_o,
    output regIndex             rs2Idx1_o
);

    localparam int IMM_W = `IMM_HI - `IMM_LO + 1;

    logic [`INSTR_W-1:0] instr [2];
    aluOp    opD    [2];
    regIndex rdD    [2];
    regIndex rs1D   [2];
    regIndex rs2D   [2];
    dataWord immD   [2];
    dataWord srcA   [2];
    dataWord srcB   [2];
    logic    useRs1 [2];
    logic    useRs2 [2];
    logic    depend [2];
    logic    accept;

    // Decode register
    logic    validQ  [2];
    aluOp    opQ     [2];
    regIndex rdQ     [2];
    dataWord opAQ    [2];
    dataWord opBQ    [2];
    regIndex rs1Q1;
    regIndex rs2Q1;
    logic    writerQ [2];

    assign instr[0] = instr0_i;
    assign instr[1] = instr1_i;

    // Slot 0 reads on ports 0 and 1 and slot 1 on ports 2 and 3
    assign rdIdx0_o = rs1D[0];
    assign rdIdx1_o = rs2D[0];
    assign rdIdx2_o = rs1D[1];
    assign rdIdx3_o = rs2D[1];
    assign srcA[0]  = rdData0_i;
    assign srcB[0]  = rdData1_i;
    assign srcA[1]  = rdData2_i;
    assign srcB[1]  = rdData3_i;

    // Slots in the register that will write a real register
    assign writerQ[0] = validQ[0] && (rdQ[0] != '0);
    assign writerQ[1] = validQ[1] && (rdQ[1] != '0);

    // --------------------
    // Per-slot decode
    // --------------------
    for (genvar s = 0; s < 2; s++) begin : gSlot
        assign opD[s]  = aluOp'(instr[s][`OPC_HI:`OPC_LO]);
        assign rdD[s]  = instr[s][`RD_HI:`RD_LO];
        assign rs1D[s] = instr[s][`RS1_HI:`RS1_LO];
        assign rs2D[s] = instr[s][`RS2_HI:`RS2_LO];
        assign immD[s] = {{(`XLEN-IMM_W){instr[s][`IMM_HI]}}, instr[s][`IMM_HI:`IMM_LO]};

        // ADDI reads rs1 only and NOP reads nothing
        assign useRs1[s] = (opD[s] != NOP);
        assign useRs2[s] = (opD[s] != NOP) && (opD[s] != ADDI);

        // Source produced by the pair now sitting in decode
        assign depend[s] =
            (useRs1[s] && (rs1D[s] != '0) &&
             ((writerQ[0] && (rs1D[s] == rdQ[0])) || (writerQ[1] && (rs1D[s] == rdQ[1])))) ||
            (useRs2[s] && (rs2D[s] != '0) &&
             ((writerQ[0] && (rs2D[s] == rdQ[0])) || (writerQ[1] && (rs2D[s] == rdQ[1]))));
    end

    // One-cycle stall while the producing pair moves on to result
    assign issueReady_o = !(depend[0] || depend[1]);
    assign accept       = issueValid_i && issueReady_o;

    // --------------------
    // Decode register
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            validQ[0] <= 1'b0;
            validQ[1] <= 1'b0;
        end else begin
            // Empty slots go through as invalid
            validQ[0] <= accept && (opD[0] != NOP);
            validQ[1] <= accept && (opD[1] != NOP);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int s = 0; s < 2; s++) begin
                opQ[s]  <= opD[s];
                rdQ[s]  <= rdD[s];
                opAQ[s] <= srcA[s];
                opBQ[s] <= (opD[s] == ADDI) ? immD[s] : srcB[s];
            end
            // Unused sources parked on x0 so the cascade check ignores them
            rs1Q1 <= useRs1[1] ? rs1D[1] : '0;
            rs2Q1 <= useRs2[1] ? rs2D[1] : '0;
        end
    end

    assign slotValid0_o = validQ[0];
    assign slotValid1_o = validQ[1];
    assign op0_o        = opQ[0];
    assign op1_o        = opQ[1];
    assign rd0_o        = rdQ[0];
    assign rd1_o        = rdQ[1];
    assign opA0_o       = opAQ[0];
    assign opA1_o       = opAQ[1];
    assign opB0_o       = opBQ[0];
    assign opB1_o       = opBQ[1];
    assign rs1Idx1_o    = rs1Q1;
    assign rs2Idx1_o    = rs2Q1;

    // The bubble behind a held pair clears the hazard by the next cycle
    stallOneCycle: assert property (@(posedge clk) disable iff (!rst)
        !issueReady_o |=> issueReady_o);

endmodule

// ==== design/executeStage.sv ====
// Two combinational ALUs for the decoded pair
// Slot 1 may consume slot 0's result in the same cycle
module executeStage import dualIssuePkg::*; (
    // Slot 0
    input  logic    slotValid0_i,
    input  aluOp    op0_i,
    input  regIndex rd0_i,
    input  dataWord opA0_i,
    input  dataWord opB0_i,
    // Slot 1
    input  logic    slotValid1_i,
    input  aluOp    op1_i,
    input  regIndex rd1_i,
    input  dataWord opA1_i,
    input  dataWord opB1_i,
    input  regIndex rs1Idx1_i,
    input  regIndex rs2Idx1_i,
    // Results
    output dataWord result0_o,
    output dataWord result1_o
);

    localparam int SHAMT_W = $clog2($bits(dataWord));

    logic    slot0Live;
    logic    slot1Live;
    logic    bypassA;
    logic    bypassB;
    dataWord opA1;
    dataWord opB1;

    // --------------------
    // ALU
    // --------------------
    function automatic dataWord aluCalc(input aluOp op, input dataWord a, input dataWord b);
        dataWord res;
        case (op)
            ADD, ADDI: res = a + b;
            SUB:       res = a - b;
            AND:       res = a & b;
            OR:        res = a | b;
            XOR:       res = a ^ b;
            SLL:       res = a << b[SHAMT_W-1:0];
            SRL:       res = a >> b[SHAMT_W-1:0];
            // Signed compare, zero extended
            SLT:       res = dataWord'($signed(a) < $signed(b));
            default:   res = '0;
        endcase
        return res;
    endfunction

    // Empty slot or x0 target yields zero
    assign slot0Live = slotValid0_i && (op0_i != NOP) && (rd0_i != '0);
    assign slot1Live = slotValid1_i && (op1_i != NOP) && (rd1_i != '0);

    assign result0_o = slot0Live ? aluCalc(op0_i, opA0_i, opB0_i) : '0;

    // --------------------
    // Cascade bypass
    // --------------------
    // Unused slot 1 sources arrive as x0, never matching a live rd0
    assign bypassA = slot0Live && (rs1Idx1_i == rd0_i);
    // Immediate operand of ADDI stays put
    assign bypassB = slot0Live && (op1_i != ADDI) && (rs2Idx1_i == rd0_i);

    assign opA1 = bypassA ? result0_o : opA1_i;
    assign opB1 = bypassB ? result0_o : opB1_i;

    assign result1_o = slot1Live ? aluCalc(op1_i, opA1, opB1) : '0;

endmodule

// ==== design/resultStage.sv ====
// Result register of the pair, write-back control and retire report
// Feeds both register file write ports and the top-level retire outputs
module resultStage import dualIssuePkg::*; (
    input  logic    clk,
    input  logic    rst,
    // From execute
    input  logic    slotValid0_i,
    input  logic    slotValid1_i,
    input  aluOp    op0_i,
    input  aluOp    op1_i,
    input  regIndex rd0_i,
    input  regIndex rd1_i,
    input  dataWord result0_i,
    input  dataWord result1_i,
    // Write-back with port 0 as the older slot
    output logic    wrEn0_o,
    output regIndex wrIdx0_o,
    output dataWord wrData0_o,
    output logic    wrEn1_o,
    output regIndex wrIdx1_o,
    output dataWord wrData1_o,
    // Retire report
    output logic    retireValid0_o,
    output logic    retireValid1_o,
    output regIndex retireRd0_o,
    output regIndex retireRd1_o,
    output dataWord retireData0_o,
    output dataWord retireData1_o
);

    logic    validQ0, validQ1;
    aluOp    opQ0, opQ1;
    regIndex rdQ0, rdQ1;
    dataWord resQ0, resQ1;

    always_ff @(posedge clk) begin
        if (!rst) begin
            validQ0 <= 1'b0;
            validQ1 <= 1'b0;
        end else begin
            validQ0 <= slotValid0_i;
            validQ1 <= slotValid1_i;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        opQ0  <= op0_i;
        opQ1  <= op1_i;
        rdQ0  <= rd0_i;
        rdQ1  <= rd1_i;
        resQ0 <= result0_i;
        resQ1 <= result1_i;
    end

    assign retireValid0_o = validQ0 && (opQ0 != NOP);
    assign retireValid1_o = validQ1 && (opQ1 != NOP);
    assign retireRd0_o    = rdQ0;
    assign retireRd1_o    = rdQ1;
    assign retireData0_o  = resQ0;
    assign retireData1_o  = resQ1;

    // --------------------
    // Write-back
    // --------------------
    // Older write dropped when the younger one hits the same register
    assign wrEn0_o   = retireValid0_o && (rdQ0 != '0) && !(retireValid1_o && (rdQ1 == rdQ0));
    assign wrEn1_o   = retireValid1_o && (rdQ1 != '0);
    assign wrIdx0_o  = rdQ0;
    assign wrIdx1_o  = rdQ1;
    assign wrData0_o = resQ0;
    assign wrData1_o = resQ1;

    // A pair aimed at one register leaves only the younger write
    youngerWriteWins: assert property (@(posedge clk) disable iff (!rst)
        (slotValid0_i && slotValid1_i && (rd0_i == rd1_i) && (rd1_i != '0))
            |=> (!wrEn0_o && wrEn1_o));

endmodule

// ==== design/dualIssueCore.sv ====
// Top of the dual-issue pipeline slice
// Decode, register file, execute and result stages wired together
module dualIssueCore import dualIssuePkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        issueValid_i,
    input  logic [31:0] instr0_i,
    input  logic [31:0] instr1_i,
    output logic        issueReady_o,
    output logic        retireValid0_o,
    output logic        retireValid1_o,
    output regIndex     retireRd0_o,
    output regIndex     retireRd1_o,
    output dataWord     retireData0_o,
    output dataWord     retireData1_o
);

    // Register file reads
    regIndex rdIdx0, rdIdx1, rdIdx2, rdIdx3;
    dataWord rdData0, rdData1, rdData2, rdData3;

    // Decode to execute
    logic    slotValid0, slotValid1;
    aluOp    op0, op1;
    regIndex rd0, rd1;
    dataWord opA0, opA1, opB0, opB1;
    regIndex rs1Idx1, rs2Idx1;

    // Execute to result
    dataWord result0, result1;

    // Write-back
    logic    wrEn0, wrEn1;
    regIndex wrIdx0, wrIdx1;
    dataWord wrData0, wrData1;

    decodeStage decodeStage_i (
        .clk(clk), .rst(rst),
        .issueValid_i(issueValid_i), .instr0_i(instr0_i), .instr1_i(instr1_i),
        .issueReady_o(issueReady_o),
        .rdIdx0_o(rdIdx0), .rdIdx1_o(rdIdx1), .rdIdx2_o(rdIdx2), .rdIdx3_o(rdIdx3),
        .rdData0_i(rdData0), .rdData1_i(rdData1), .rdData2_i(rdData2), .rdData3_i(rdData3),
        .slotValid0_o(slotValid0), .slotValid1_o(slotValid1),
        .op0_o(op0), .op1_o(op1), .rd0_o(rd0), .rd1_o(rd1),
        .opA0_o(opA0), .opA1_o(opA1), .opB0_o(opB0), .opB1_o(opB1),
        .rs1Idx1_o(rs1Idx1), .rs2Idx1_o(rs2Idx1)
    );

    regFile regFile_i (
        .clk(clk), .rst(rst),
        .rdIdx0_i(rdIdx0), .rdIdx1_i(rdIdx1), .rdIdx2_i(rdIdx2), .rdIdx3_i(rdIdx3),
        .rdData0_o(rdData0), .rdData1_o(rdData1), .rdData2_o(rdData2), .rdData3_o(rdData3),
        .wrEn0_i(wrEn0), .wrIdx0_i(wrIdx0), .wrData0_i(wrData0),
        .wrEn1_i(wrEn1), .wrIdx1_i(wrIdx1), .wrData1_i(wrData1)
    );

    executeStage executeStage_i (
        .slotValid0_i(slotValid0), .op0_i(op0), .rd0_i(rd0), .opA0_i(opA0), .opB0_i(opB0),
        .slotValid1_i(slotValid1), .op1_i(op1), .rd1_i(rd1), .opA1_i(opA1), .opB1_i(opB1),
        .rs1Idx1_i(rs1Idx1), .rs2Idx1_i(rs2Idx1),
        .result0_o(result0), .result1_o(result1)
    );

    resultStage resultStage_i (
        .clk(clk), .rst(rst),
        .slotValid0_i(slotValid0), .slotValid1_i(slotValid1),
        .op0_i(op0), .op1_i(op1), .rd0_i(rd0), .rd1_i(rd1),
        .result0_i(result0), .result1_i(result1),
        .wrEn0_o(wrEn0), .wrIdx0_o(wrIdx0), .wrData0_o(wrData0),
        .wrEn1_o(wrEn1), .wrIdx1_o(wrIdx1), .wrData1_o(wrData1),
        .retireValid0_o(retireValid0_o), .retireValid1_o(retireValid1_o),
        .retireRd0_o(retireRd0_o), .retireRd1_o(retireRd1_o),
        .retireData0_o(retireData0_o), .retireData1_o(retireData1_o)
    );

endmodule

// ==== dv/clockGen.sv ====
// Testbench clock with period 4 and active-low reset
// Reset is released after the fourth rising edge
module clockGen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Held low for 4 cycles
    initial begin
        rst_o = 1'b0;
        repeat (4) @(posedge clk_o);
        rst_o <= 1'b1;
    end

endmodule

// ==== dv/dualIssueTb.sv ====
// Testbench of the dual-issue core with pairs and expected retires from dv/coreStim.txt
// Drives each pair until accepted and checks retires in issue order
`include "core_settings.svh"

module dualIssueTb import dualIssuePkg::*; ();

    localparam int STIM_LINES = 18;
    localparam int WORDS      = 8;
    // Lines 2, 9 and 14 each depend on the pair just ahead of them
    localparam int EXP_STALLS = 3;
    // 3 cycles per line plus slack for reset and drain
    localparam int TIMEOUT    = 3 * STIM_LINES + 20;

    logic                clk;
    logic                rst;
    logic                issueValid;
    logic [`INSTR_W-1:0] instr0;
    logic [`INSTR_W-1:0] instr1;
    logic                issueReady;
    logic                retireValid0;
    logic                retireValid1;
    regIndex             retireRd0;
    regIndex             retireRd1;
    dataWord             retireData0;
    dataWord             retireData1;

    // Flat image of the stim file with 8 words per line
    logic [31:0] stim [STIM_LINES*WORDS];
    // Line numbers of accepted pairs still in flight
    int          expQ [$];
    int          cycles;
    int          stallCount;

    clockGen clockGen_i (
        .clk_o(clk),
        .rst_o(rst)
    );

    dualIssueCore dualIssueCore_i (
        .clk(clk), .rst(rst),
        .issueValid_i(issueValid), .instr0_i(instr0), .instr1_i(instr1),
        .issueReady_o(issueReady),
        .retireValid0_o(retireValid0), .retireValid1_o(retireValid1),
        .retireRd0_o(retireRd0), .retireRd1_o(retireRd1),
        .retireData0_o(retireData0), .retireData1_o(retireData1)
    );

    // --------------------
    // Compare tasks
    // --------------------
    task automatic checkValid(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("** Error at %0t: %s expected %b got %b", $time, name, exp, got);
            $display("** FAIL **");
            $fatal(1, "retire strobe mismatch");
        end
    endtask

    task automatic checkIndex(input string name, input regIndex exp, input regIndex got);
        if (got !== exp) begin
            $display("** Error at %0t: %s expected %0d got %0d", $time, name, exp, got);
            $display("** FAIL **");
            $fatal(1, "retire index mismatch");
        end
    endtask

    task automatic checkData(input string name, input dataWord exp, input dataWord got);
        if (got !== exp) begin
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
            $display("** FAIL **");
            $fatal(1, "retire data mismatch");
        end
    endtask

    // Both slots of one stim line against the retire ports
    task automatic checkRetire(input int line);
        int base;
        base = line * WORDS;
        checkValid("retireValid0_o", stim[base+2][0], retireValid0);
        checkValid("retireValid1_o", stim[base+5][0], retireValid1);
        // Index and data only matter for a retiring slot
        if (stim[base+2][0]) begin
            checkIndex("retireRd0_o", regIndex'(stim[base+3]), retireRd0);
            checkData("retireData0_o", dataWord'(stim[base+4]), retireData0);
        end
        if (stim[base+5][0]) begin
            checkIndex("retireRd1_o", regIndex'(stim[base+6]), retireRd1);
            checkData("retireData1_o", dataWord'(stim[base+7]), retireData1);
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        int   waited;
        logic accepted;
        logic readySample;
        issueValid = 1'b0;
        instr0     = '0;
        instr1     = '0;
        stallCount = 0;
        $readmemh("dv/coreStim.txt", stim);
        @(posedge clk);
        while (!rst) @(posedge clk);
        for (int l = 0; l < STIM_LINES; l++) begin
            #1;
            issueValid = 1'b1;
            instr0     = stim[l*WORDS];
            instr1     = stim[l*WORDS+1];
            waited     = 0;
            accepted   = 1'b0;
            // Hold the pair until the edge that takes it
            while (!accepted) begin
                @(negedge clk);
                readySample = issueReady;
                @(posedge clk);
                if (readySample) begin
                    accepted = 1'b1;
                    expQ.push_back(l);
                end else begin
                    waited++;
                    stallCount++;
                    if (waited > 1) begin
                        $display("Stall on line %0d lasted more than one cycle", l);
                        $display("** FAIL **");
                        $fatal(1, "stall too long");
                    end
                end
            end
        end
        #1;
        issueValid = 1'b0;
        // Drain the pipe
        while (expQ.size() != 0) @(negedge clk);
        if (stallCount != EXP_STALLS) begin
            $display("Saw %0d stall cycles where %0d dependent pairs were issued",
                     stallCount, EXP_STALLS);
            $display("** FAIL **");
            $fatal(1, "wrong stall count");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

    // --------------------
    // Retire monitor
    // --------------------
    // Sampled mid-cycle where the retire ports are settled
    always @(negedge clk) begin
        if (rst && (retireValid0 || retireValid1)) begin
            if (expQ.size() == 0) begin
                $display("Retire at %0t with no pair outstanding", $time);
                $display("** FAIL **");
                $fatal(1, "unexpected retire");
            end else begin
                checkRetire(expQ.pop_front());
            end
        end
    end

    // Timeout
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, retires did not complete", TIMEOUT);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    initial cycles = 0;

endmodule

// ==== tb.f ====
+incdir+include
design/dualIssuePkg.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/resultStage.sv
design/dualIssueCore.sv
dv/clockGen.sv
dv/dualIssueTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the dual-issue core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -f tb.f --top-module dualIssueTb \
    --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -F -q "** FAIL **" sim.log; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi
exit 0

// ==== dv/coreStim.txt ====
// instr0 instr1 expValid0 expRd0 expData0 expValid1 expRd1 expData1
// Loads, ALU ops, cascade, stall, forwarding, write-after-write, x0, NOP slots
90800064 91001FFD 1 01 00000064 1 02 FFFFFFFD
918000F0 92000005 1 03 000000F0 1 04 00000005
12846000 23088000 1 05 00000154 1 06 FFFFFFF8
33846000 44046000 1 07 00000060 1 08 000000F4
54846000 65108000 1 09 00000094 1 0A 000000A0
75888000 86184000 1 0B 07FFFFFF 1 0C 00000001
8688C000 97041F38 1 0D 00000000 1 0E FFFFFF9C
17848000 283C2000 1 0F 00000069 1 10 00000005
98800007 29122000 1 11 00000007 1 12 FFFFFFFE
19CA2000 1A41E000 1 13 00000005 1 14 0000006E
9A800123 00000000 1 15 00000123 0 00 00000000
00000000 9B000001 0 00 00000000 1 16 00000001
1BD66000 00000000 1 17 00000128 0 00 00000000
9C00000B 9C000016 1 18 0000000B 1 18 00000016
1CE00000 4D630000 1 19 00000016 1 1A 00000016
90000037 1D802000 1 00 00000000 1 1B 00000064
1E000000 00000000 1 1C 00000000 0 00 00000000
00000000 6E848000 0 00 00000000 1 1D 00000C80
